// ==== bench/hmc_link_assertions.sv ====
// Bound into hmc_req_encoder; covers the TX valid/ready handshake and the state right after reset
`timescale 1ns/1ps
`default_nettype none

module hmc_link_assertions import axis_flit_pkg::*; (
  input logic               CLK,
  input logic               RST,
  input logic               wr_ready_o,
  input logic               rd_ready_o,
  input logic               tx_tvalid_o,
  input logic               tx_tready_i,
  input logic [WORD_W-1:0]  tx_tdata_o,
  input logic [TUSER_W-1:0] tx_tuser_o
);

  // Count of failed assertions, looked at when the run ends
  int unsigned fail_cnt = 0;

  // ------------------------------
  // TX handshake
  // ------------------------------
  // Stalled word keeps its payload
  a_tx_stable: assert property (@(posedge CLK) disable iff (RST)
    tx_tvalid_o && !tx_tready_i |=> $stable(tx_tdata_o) && $stable(tx_tuser_o))
    else begin
      $error("TX payload changed while stalled");
      fail_cnt++;
    end

  // Valid only drops after a cycle with ready
  a_tx_hold: assert property (@(posedge CLK) disable iff (RST)
    tx_tvalid_o && !tx_tready_i |=> tx_tvalid_o)
    else begin
      $error("TX valid dropped without ready");
      fail_cnt++;
    end

  // ------------------------------
  // Reset state
  // ------------------------------
  a_rst_idle: assert property (@(posedge CLK)
    RST |=> !tx_tvalid_o && !wr_ready_o && !rd_ready_o)
    else begin
      $error("TX valid or request ready high after reset");
      fail_cnt++;
    end

endmodule

bind hmc_req_encoder hmc_link_assertions i_link_assertions (
  .CLK(CLK), .RST(RST), .wr_ready_o(wr_ready_o), .rd_ready_o(rd_ready_o),
  .tx_tvalid_o(tx_tvalid_o), .tx_tready_i(tx_tready_i),
  .tx_tdata_o(tx_tdata_o), .tx_tuser_o(tx_tuser_o)
);

`default_nettype wire

// ==== bench/tb_hmc_link_user.sv ====
// Stops at the first mismatch; requests and responses run in separate phases, post_done_i stays high
`timescale 1ns/1ps
`default_nettype none

module tb_hmc_link_user import axis_flit_pkg::*; import hmc_pkg::*; ();

  localparam int N_REQ          = 48;
  localparam int N_RSP          = 32;
  localparam int TIMEOUT_CYCLES = (INIT_WAIT_CYCLES + 40 * (N_REQ + N_RSP)) * 2;

  logic               CLK;
  logic               RST;
  logic               post_done_i;
  logic               wr_valid_i, wr_ready_o, rd_valid_i, rd_ready_o;
  logic [ADDR_W-1:0]  wr_addr_i, rd_addr_i;
  logic [DATA_W-1:0]  wr_data_i, rd_data_o;
  logic [TAG_W-1:0]   rd_tag_i, rd_tag_o;
  logic               tx_tvalid_o, tx_tready_i, rx_tvalid_i, rx_tready_o, rd_data_valid_o;
  logic [WORD_W-1:0]  tx_tdata_o, rx_tdata_i;
  logic [TUSER_W-1:0] tx_tuser_o, rx_tuser_i;

  // Model state
  logic [31:0]        lfsr_state = 32'd70673;
  logic [WORD_W-1:0]  exp_tx_data [$];
  logic [TUSER_W-1:0] exp_tx_user [$];
  logic [DATA_W-1:0]  exp_rd_data [$];
  logic [TAG_W-1:0]   exp_rd_tag [$];
  // Current RX word completes a response
  logic               rx_last = 1'b0;
  logic               rsp_due = 1'b0;
  // A request was accepted in the previous cycle
  logic               tx_due = 1'b0;
  int                 cycle_cnt = 0;
  int                 n_issued = 0;
  int                 n_acc = 0;
  int                 n_tx = 0;

  hmc_link_user i_dut (.*);

  // ------------------------------
  // Random numbers and model
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [DATA_W-1:0] rand_bits(input int n);
    logic [DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v[i] = lfsr_state[0];
    end
    return v;
  endfunction

  // cub, res, addr, tag, dln, lng, res, cmd from bit 63 down
  function automatic logic [63:0] expected_header(input logic [5:0] cmd, input logic [3:0] lng,
                                                  input logic [ADDR_W-1:0] addr,
                                                  input logic [TAG_W-1:0] tag);
    return {6'd0, 2'b00, addr, 5'd0, tag, lng, lng, 1'b0, cmd};
  endfunction

  function automatic logic [TUSER_W-1:0] tuser_flags(input logic [3:0] v, input logic [3:0] h,
                                                     input logic [3:0] t);
    logic [TUSER_W-1:0] u;
    u = '0;
    u[TUSER_VALID_LSB +: FLITS_PER_WORD] = v;
    u[TUSER_HDR_LSB +: FLITS_PER_WORD]   = h;
    u[TUSER_TAIL_LSB +: FLITS_PER_WORD]  = t;
    return u;
  endfunction

  // ------------------------------
  // Failure reporting
  // ------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [WORD_W-1:0] exp,
                       input logic [WORD_W-1:0] act);
    if (exp !== act)
      abort_run($sformatf("ERR %s expected %0h actual %0h", name, exp, act));
  endtask

  // ------------------------------
  // Clock, timeout and monitor
  // ------------------------------
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      abort_run("Timeout, the DUT stopped making progress before all tests finished");
  end

  // Inputs and outputs are all settled at the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      // Accepted request shows up on TX the next cycle
      if (tx_due)
        check("tx_tvalid_o after accept", 1'b1, tx_tvalid_o);
      if (wr_valid_i && rd_valid_i)
        check("write priority", '0, rd_ready_o);
      if (tx_tvalid_o && !tx_tready_i)
        check("ready while held", '0, wr_ready_o || rd_ready_o);
      // Taken word leaves the queue before a new request joins it
      if (tx_tvalid_o && tx_tready_i) begin
        if (exp_tx_data.size() == 0)
          abort_run("A TX word was sent without an accepted request");
        check("tx_tdata_o", exp_tx_data.pop_front(), tx_tdata_o);
        check("tx_tuser_o", exp_tx_user.pop_front(), tx_tuser_o);
        n_tx++;
      end
      if (wr_valid_i && wr_ready_o) begin
        exp_tx_data.push_back({128'd0, 64'd0, wr_data_i,
                               expected_header(CMD_P_WR32, LNG_WR32, wr_addr_i, '0)});
        exp_tx_user.push_back(tuser_flags(4'b0111, 4'b0001, 4'b0100));
        n_acc++;
      end else if (rd_valid_i && rd_ready_o) begin
        exp_tx_data.push_back({384'd0, 64'd0,
                               expected_header(CMD_RD32, LNG_RD32, rd_addr_i, rd_tag_i)});
        exp_tx_user.push_back(tuser_flags(4'b0001, 4'b0001, 4'b0001));
        n_acc++;
      end
      check("one request in flight", 1'b1, exp_tx_data.size() <= 1);
      // Pulse exactly one cycle after a completing RX word
      check("rd_data_valid_o", rsp_due, rd_data_valid_o);
      if (rd_data_valid_o) begin
        check("rd_tag_o", exp_rd_tag.pop_front(), rd_tag_o);
        check("rd_data_o", exp_rd_data.pop_front(), rd_data_o);
      end
      rsp_due = rx_tvalid_i && rx_tready_o && rx_last;
      tx_due  = (wr_valid_i && wr_ready_o) || (rd_valid_i && rd_ready_o);
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  // Write, read or both at once, with random TX back-pressure
  task automatic send_request();
    logic [1:0] kind;
    logic       wr_took;
    logic       rd_took;
    kind = 2'(rand_bits(2));
    @(posedge CLK);
    #1;
    wr_valid_i  = (kind != 2'd1);
    rd_valid_i  = (kind != 2'd0);
    wr_addr_i   = ADDR_W'(rand_bits(ADDR_W));
    wr_data_i   = rand_bits(DATA_W);
    rd_addr_i   = ADDR_W'(rand_bits(ADDR_W));
    rd_tag_i    = TAG_W'(rand_bits(TAG_W));
    tx_tready_i = (2'(rand_bits(2)) != 2'd0);
    n_issued    = n_issued + int'(wr_valid_i) + int'(rd_valid_i);
    while (wr_valid_i || rd_valid_i) begin
      @(negedge CLK);
      wr_took = wr_valid_i && wr_ready_o;
      rd_took = rd_valid_i && rd_ready_o;
      @(posedge CLK);
      #1;
      if (wr_took)
        wr_valid_i = 1'b0;
      if (rd_took)
        rd_valid_i = 1'b0;
      tx_tready_i = (2'(rand_bits(2)) != 2'd0);
    end
  endtask

  // Called and left 1 ns after a rising edge
  task automatic drive_rx_word(input logic [WORD_W-1:0] d, input logic [TUSER_W-1:0] u,
                               input logic last);
    rx_tvalid_i = 1'b1;
    rx_tdata_i  = d;
    rx_tuser_i  = u;
    rx_last     = last;
    do @(negedge CLK); while (!rx_tready_o);
    @(posedge CLK);
    #1;
    rx_tvalid_i = 1'b0;
    rx_last     = 1'b0;
  endtask

  // Three flits placed at header position 0..3 over an eight-flit window
  task automatic send_response();
    logic [1:0]          pos;
    logic [TAG_W-1:0]    tag;
    logic [DATA_W-1:0]   data;
    logic [63:0]         hdr;
    logic [2*WORD_W-1:0] flits;
    logic [7:0]          v;
    logic [7:0]          h;
    logic [7:0]          t;
    pos        = 2'(rand_bits(2));
    tag        = TAG_W'(rand_bits(TAG_W));
    data       = rand_bits(DATA_W);
    hdr        = 64'(rand_bits(64));
    hdr[23:15] = tag;
    flits      = '0;
    flits[pos*FLIT_W +: 3*FLIT_W] = {64'(rand_bits(64)), data, hdr};
    v = 8'b0000_0111 << pos;
    h = 8'b0000_0001 << pos;
    t = 8'b0000_0100 << pos;
    exp_rd_tag.push_back(tag);
    exp_rd_data.push_back(data);
    drive_rx_word(flits[WORD_W-1:0], tuser_flags(v[3:0], h[3:0], t[3:0]), pos < 2'd2);
    if (pos >= 2'd2) begin
      // Idle cycles before the continuation word
      repeat (int'(rand_bits(2))) begin
        @(posedge CLK);
        #1;
      end
      drive_rx_word(flits[2*WORD_W-1:WORD_W], tuser_flags(v[7:4], h[7:4], t[7:4]), 1'b1);
    end
  endtask

  initial begin
    int delay;
    RST         = 1'b1;
    post_done_i = 1'b0;
    wr_valid_i  = 1'b0;
    wr_addr_i   = '0;
    wr_data_i   = '0;
    rd_valid_i  = 1'b0;
    rd_addr_i   = '0;
    rd_tag_i    = '0;
    tx_tready_i = 1'b0;
    rx_tvalid_i = 1'b0;
    rx_tdata_i  = '0;
    rx_tuser_i  = '0;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Start-up hold-off from a random link-up time
    delay = int'(rand_bits(4));
    repeat (delay) begin
      @(posedge CLK);
      #1;
    end
    tx_tready_i = 1'b1;
    post_done_i = 1'b1;
    for (int i = 0; i < INIT_WAIT_CYCLES; i++) begin
      @(negedge CLK);
      check("hold-off wr_ready_o", '0, wr_ready_o);
      check("hold-off rd_ready_o", '0, rd_ready_o);
      // RX opens on the edge that first sees post_done_i
      check("rx_tready_o at link-up", i != 0, rx_tready_o);
    end
    while (!wr_ready_o)
      @(negedge CLK);
    check("rd_ready_o after hold-off", 1'b1, rd_ready_o);
    check("rx_tready_o after link-up", 1'b1, rx_tready_o);
    @(posedge CLK);
    #1;

    // Write and read encoding under back-pressure
    repeat (N_REQ)
      send_request();
    tx_tready_i = 1'b1;
    repeat (3) @(negedge CLK);
    check("accepted requests", n_issued, n_acc);
    check("TX words sent", n_issued, n_tx);
    @(posedge CLK);
    #1;

    // Single-word and spanning read responses
    repeat (N_RSP) begin
      send_response();
      if (rand_bits(1) != 0) begin
        @(posedge CLK);
        #1;
      end
    end
    repeat (3) @(negedge CLK);
    check("read results outstanding", '0, exp_rd_tag.size());

    if (i_dut.i_req_encoder.i_link_assertions.fail_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run("One or more bound TX assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

// ==== hdl/axis_flit_pkg.sv ====
// Fixed openHMC geometry: four 128-bit flits per 512-bit word; only TUSER[11:0] carry flags
`default_nettype none

package axis_flit_pkg;

  // ------------------------------
  // Word geometry
  // ------------------------------
  // Flit 0 sits in TDATA[127:0] and is processed first
  localparam int FLIT_W         = 128;
  localparam int FLITS_PER_WORD = 4;
  localparam int WORD_W         = FLIT_W * FLITS_PER_WORD;

  // TUSER is one bit per data byte on the openHMC AXI ports
  localparam int TUSER_W = WORD_W / 8;

  // ------------------------------
  // TUSER flag groups
  // ------------------------------
  // Each group holds one bit per flit, bit 0 of a group is flit 0
  // Flit is valid
  localparam int TUSER_VALID_LSB = 0;
  // Flit carries a packet header
  localparam int TUSER_HDR_LSB   = 4;
  // Flit carries a packet tail
  localparam int TUSER_TAIL_LSB  = 8;

endpackage

`default_nettype wire

// ==== hdl/hmc_link_user.sv ====
// Expects post_done_i to stay high once set; read results have no back-pressure
`timescale 1ns/1ps
`default_nettype none

module hmc_link_user import axis_flit_pkg::*; import hmc_pkg::*; (
  input  logic               CLK,
  input  logic               RST,
  input  logic               post_done_i,
  // Write requests
  input  logic               wr_valid_i,
  input  logic [ADDR_W-1:0]  wr_addr_i,
  input  logic [DATA_W-1:0]  wr_data_i,
  output logic               wr_ready_o,
  // Read requests
  input  logic               rd_valid_i,
  input  logic [ADDR_W-1:0]  rd_addr_i,
  input  logic [TAG_W-1:0]   rd_tag_i,
  output logic               rd_ready_o,
  // openHMC TX stream
  output logic               tx_tvalid_o,
  input  logic               tx_tready_i,
  output logic [WORD_W-1:0]  tx_tdata_o,
  output logic [TUSER_W-1:0] tx_tuser_o,
  // openHMC RX stream
  input  logic               rx_tvalid_i,
  output logic               rx_tready_o,
  input  logic [WORD_W-1:0]  rx_tdata_i,
  input  logic [TUSER_W-1:0] rx_tuser_i,
  // Read results
  output logic               rd_data_valid_o,
  output logic [DATA_W-1:0]  rd_data_o,
  output logic [TAG_W-1:0]   rd_tag_o
);

  // Request side owns TX and both request handshakes
  hmc_req_encoder i_req_encoder (
    .CLK(CLK), .RST(RST), .post_done_i(post_done_i),
    .wr_valid_i(wr_valid_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
    .rd_valid_i(rd_valid_i), .rd_addr_i(rd_addr_i), .rd_tag_i(rd_tag_i),
    .tx_tready_i(tx_tready_i), .wr_ready_o(wr_ready_o), .rd_ready_o(rd_ready_o),
    .tx_tvalid_o(tx_tvalid_o), .tx_tdata_o(tx_tdata_o), .tx_tuser_o(tx_tuser_o)
  );

  // Response side owns RX and the read results
  hmc_rsp_decoder i_rsp_decoder (
    .CLK(CLK), .RST(RST), .post_done_i(post_done_i),
    .rx_tvalid_i(rx_tvalid_i), .rx_tdata_i(rx_tdata_i), .rx_tuser_i(rx_tuser_i),
    .rx_tready_o(rx_tready_o), .rd_data_valid_o(rd_data_valid_o),
    .rd_data_o(rd_data_o), .rd_tag_o(rd_tag_o)
  );

endmodule

`default_nettype wire

// ==== hdl/hmc_pkg.sv ====
// HMC request and response fields for 32-byte packets only; tail is left zero for the controller to fill
`default_nettype none

package hmc_pkg;

  import axis_flit_pkg::*;

  // ------------------------------
  // User side widths
  // ------------------------------
  // Address counts 32-byte blocks
  localparam int ADDR_W = 27;
  localparam int TAG_W  = 9;
  localparam int DATA_W = 256;

  // Time to let NULL flits drain after link training
  localparam int INIT_WAIT_CYCLES = 256;
  localparam int INIT_CNT_W       = $clog2(INIT_WAIT_CYCLES);

  // ------------------------------
  // Commands and lengths
  // ------------------------------
  // Posted write, no response comes back
  localparam logic [5:0] CMD_P_WR32 = 6'b011001;
  // Read, answered by RD_RS with the same tag
  localparam logic [5:0] CMD_RD32   = 6'b110001;

  // Lengths in flits, header and tail included
  localparam logic [3:0] LNG_WR32 = 4'd3;
  localparam logic [3:0] LNG_RD32 = 4'd1;

  // Request header, bit 63 first
  typedef struct packed {
    logic [2:0]       cub;
    logic [2:0]       res_hi;
    // Byte address, 16-byte granular
    logic [33:0]      addr;
    logic [TAG_W-1:0] tag;
    // Copy of lng
    logic [3:0]       dln;
    logic [3:0]       lng;
    logic             res_lo;
    logic [5:0]       cmd;
  } hmc_req_hdr_t;

  // One flit, seen either as header plus first payload or as plain data
  typedef union packed {
    struct packed {
      logic [FLIT_W-$bits(hmc_req_hdr_t)-1:0] upper;
      hmc_req_hdr_t                           hdr;
    } hdr_view;
    logic [FLIT_W-1:0] raw;
  } hmc_flit_u;

endpackage

`default_nettype wire

// ==== hdl/hmc_req_encoder.sv ====
// One request in flight at a time; write wins over read; posted writes always carry tag 0
`timescale 1ns/1ps
`default_nettype none

module hmc_req_encoder import axis_flit_pkg::*; import hmc_pkg::*; (
  input  logic               CLK,
  input  logic               RST,
  input  logic               post_done_i,
  input  logic               wr_valid_i,
  input  logic [ADDR_W-1:0]  wr_addr_i,
  input  logic [DATA_W-1:0]  wr_data_i,
  input  logic               rd_valid_i,
  input  logic [ADDR_W-1:0]  rd_addr_i,
  input  logic [TAG_W-1:0]   rd_tag_i,
  input  logic               tx_tready_i,
  output logic               wr_ready_o,
  output logic               rd_ready_o,
  output logic               tx_tvalid_o,
  output logic [WORD_W-1:0]  tx_tdata_o,
  output logic [TUSER_W-1:0] tx_tuser_o
);

  logic [INIT_CNT_W-1:0] init_cnt;
  logic                  link_open;
  logic                  slot_free;
  logic                  wr_fire;
  logic                  rd_fire;
  hmc_flit_u             wr_flit [3];
  hmc_flit_u             rd_flit;
  logic [WORD_W-1:0]     wr_word;
  logic [WORD_W-1:0]     rd_word;
  logic [TUSER_W-1:0]    wr_user;
  logic [TUSER_W-1:0]    rd_user;

  // Request header with cub and reserved bits at zero
  function automatic hmc_req_hdr_t req_hdr(input logic [5:0] cmd, input logic [3:0] lng,
                                           input logic [ADDR_W-1:0] addr,
                                           input logic [TAG_W-1:0] tag);
    hmc_req_hdr_t h;
    h      = '0;
    // 32-byte block number to byte address
    h.addr = {2'b00, addr, 5'b00000};
    h.tag  = tag;
    h.dln  = lng;
    h.lng  = lng;
    h.cmd  = cmd;
    return h;
  endfunction

  // ------------------------------
  // Link-up hold-off
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      init_cnt  <= '0;
      link_open <= 1'b0;
    end else if (post_done_i && !link_open) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == INIT_CNT_W'(INIT_WAIT_CYCLES - 1))
        link_open <= 1'b1;
    end
  end

  // Output register empty, or emptied by TX this cycle
  assign slot_free  = !tx_tvalid_o || tx_tready_i;
  assign wr_ready_o = link_open && slot_free;
  // Read only gets the slot when no write asks for it
  assign rd_ready_o = link_open && slot_free && !wr_valid_i;
  assign wr_fire    = wr_valid_i && wr_ready_o;
  assign rd_fire    = rd_valid_i && rd_ready_o;

  // ------------------------------
  // Packet building
  // ------------------------------
  always_comb begin
    // P_WR32: header + data[63:0], data[191:64], data[255:192] + zero tail
    wr_flit[0].hdr_view.hdr   = req_hdr(CMD_P_WR32, LNG_WR32, wr_addr_i, '0);
    wr_flit[0].hdr_view.upper = wr_data_i[63:0];
    wr_flit[1].raw            = wr_data_i[191:64];
    wr_flit[2].raw            = {64'd0, wr_data_i[255:192]};
    // Flit 3 is padding
    wr_word = {{FLIT_W{1'b0}}, wr_flit[2].raw, wr_flit[1].raw, wr_flit[0].raw};
    // RD32: header and zero tail in flit 0 only
    rd_flit.hdr_view.hdr   = req_hdr(CMD_RD32, LNG_RD32, rd_addr_i, rd_tag_i);
    rd_flit.hdr_view.upper = '0;
    rd_word = {{(WORD_W-FLIT_W){1'b0}}, rd_flit.raw};
  end

  always_comb begin
    wr_user = '0;
    wr_user[TUSER_VALID_LSB +: FLITS_PER_WORD] = 4'b0111;
    wr_user[TUSER_HDR_LSB +: FLITS_PER_WORD]   = 4'b0001;
    wr_user[TUSER_TAIL_LSB +: FLITS_PER_WORD]  = 4'b0100;
    // Single flit is header and tail at once
    rd_user = '0;
    rd_user[TUSER_VALID_LSB +: FLITS_PER_WORD] = 4'b0001;
    rd_user[TUSER_HDR_LSB +: FLITS_PER_WORD]   = 4'b0001;
    rd_user[TUSER_TAIL_LSB +: FLITS_PER_WORD]  = 4'b0001;
  end

  // ------------------------------
  // Held TX word
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST)
      tx_tvalid_o <= 1'b0;
    else if (wr_fire || rd_fire)
      tx_tvalid_o <= 1'b1;
    else if (tx_tready_i)
      tx_tvalid_o <= 1'b0;
  end

  // Payload only loads on an accepted request, so it holds under back-pressure
  always_ff @(posedge CLK) begin
    if (wr_fire) begin
      tx_tdata_o <= wr_word;
      tx_tuser_o <= wr_user;
    end else if (rd_fire) begin
      tx_tdata_o <= rd_word;
      tx_tuser_o <= rd_user;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hmc_rsp_decoder.sv ====
// At most one response completes per RX word; response error fields and CRC are not checked
`timescale 1ns/1ps
`default_nettype none

module hmc_rsp_decoder import axis_flit_pkg::*; import hmc_pkg::*; (
  input  logic               CLK,
  input  logic               RST,
  input  logic               post_done_i,
  input  logic               rx_tvalid_i,
  input  logic [WORD_W-1:0]  rx_tdata_i,
  input  logic [TUSER_W-1:0] rx_tuser_i,
  output logic               rx_tready_o,
  output logic               rd_data_valid_o,
  output logic [DATA_W-1:0]  rd_data_o,
  output logic [TAG_W-1:0]   rd_tag_o
);

  hmc_flit_u                   rx_flit [FLITS_PER_WORD];
  logic [FLITS_PER_WORD-1:0]   vld;
  logic [FLITS_PER_WORD-1:0]   hdr;
  logic [FLITS_PER_WORD-1:0]   tail;
  logic                        rx_take;
  // Partial response waiting for its continuation word
  logic                        wait_pos2;
  logic                        wait_pos3;
  logic [191:0]                part_data;
  logic [TAG_W-1:0]            part_tag;
  // Decode results of the current word
  logic                        cmp_hit;
  logic [DATA_W-1:0]           cmp_data;
  logic [TAG_W-1:0]            cmp_tag;
  logic                        span_pos2;
  logic                        span_pos3;

  // Split the word into flits, flit 0 in the low bits
  for (genvar i = 0; i < FLITS_PER_WORD; i++) begin : g_flit
    assign rx_flit[i].raw = rx_tdata_i[i*FLIT_W +: FLIT_W];
  end

  assign vld  = rx_tuser_i[TUSER_VALID_LSB +: FLITS_PER_WORD];
  assign hdr  = rx_tuser_i[TUSER_HDR_LSB +: FLITS_PER_WORD];
  assign tail = rx_tuser_i[TUSER_TAIL_LSB +: FLITS_PER_WORD];

  // Always ready once the link is up
  always_ff @(posedge CLK) begin
    if (RST)
      rx_tready_o <= 1'b0;
    else if (post_done_i)
      rx_tready_o <= 1'b1;
  end

  assign rx_take = rx_tvalid_i && rx_tready_o;

  // ------------------------------
  // Position decode
  // ------------------------------
  always_comb begin
    cmp_hit  = 1'b0;
    cmp_data = '0;
    cmp_tag  = '0;
    if (wait_pos2 && tail[0] && vld[0]) begin
      // Flit 0 finishes a response started at position 2
      cmp_hit  = 1'b1;
      cmp_data = {rx_flit[0].raw[63:0], part_data};
      cmp_tag  = part_tag;
    end else if (wait_pos3 && tail[1] && vld[1:0] == 2'b11) begin
      // Flits 0 and 1 finish a response started at position 3
      cmp_hit  = 1'b1;
      cmp_data = {rx_flit[1].raw[63:0], rx_flit[0].raw, part_data[63:0]};
      cmp_tag  = part_tag;
    end else if (hdr[0] && tail[2] && vld[2:0] == 3'b111) begin
      cmp_hit  = 1'b1;
      cmp_data = {rx_flit[2].raw[63:0], rx_flit[1].raw, rx_flit[0].hdr_view.upper};
      cmp_tag  = rx_flit[0].hdr_view.hdr.tag;
    end else if (hdr[1] && tail[3] && vld[3:1] == 3'b111) begin
      cmp_hit  = 1'b1;
      cmp_data = {rx_flit[3].raw[63:0], rx_flit[2].raw, rx_flit[1].hdr_view.upper};
      cmp_tag  = rx_flit[1].hdr_view.hdr.tag;
    end
    // Headers in the upper flits run over into the next word
    span_pos2 = hdr[2] && !tail[2] && !tail[3] && vld[3:2] == 2'b11;
    span_pos3 = hdr[3] && !tail[3] && vld[3];
  end

  // ------------------------------
  // Partial response store
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      wait_pos2 <= 1'b0;
      wait_pos3 <= 1'b0;
    end else if (rx_take) begin
      // Any accepted word ends the wait; a new span may start in the same word
      wait_pos2 <= span_pos2;
      wait_pos3 <= span_pos3;
    end
  end

  always_ff @(posedge CLK) begin
    if (rx_take && span_pos2) begin
      part_data <= {rx_flit[3].raw, rx_flit[2].hdr_view.upper};
      part_tag  <= rx_flit[2].hdr_view.hdr.tag;
    end else if (rx_take && span_pos3) begin
      part_data[63:0] <= rx_flit[3].hdr_view.upper;
      part_tag        <= rx_flit[3].hdr_view.hdr.tag;
    end
  end

  // ------------------------------
  // Read result
  // ------------------------------
  // One-cycle pulse the cycle after the completing word
  always_ff @(posedge CLK) begin
    if (RST)
      rd_data_valid_o <= 1'b0;
    else
      rd_data_valid_o <= rx_take && cmp_hit;
  end

  always_ff @(posedge CLK) begin
    if (rx_take && cmp_hit) begin
      rd_data_o <= cmp_data;
      rd_tag_o  <= cmp_tag;
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/axis_flit_pkg.sv
hdl/hmc_pkg.sv
hdl/hmc_req_encoder.sv
hdl/hmc_rsp_decoder.sv
hdl/hmc_link_user.sv
bench/hmc_link_assertions.sv
bench/tb_hmc_link_user.sv
